//--- hw/lsu_pkg.sv
package lsu_pkg;

    // ========================================
    // Widths and sizes
    // ========================================
    localparam int ADDR_W   = 32;
    localparam int XLEN     = 32;
    // Memory side is a 64-bit word with byte strobes
    localparam int MEM_W    = 64;
    localparam int STRB_W   = 8;
    // Store queue geometry
    localparam int SQ_DEPTH = 4;
    localparam int SQ_PTR_W = 2;
    // Destination tag carried from issue to writeback
    localparam int TAG_W    = 5;

    // ========================================
    // Encodings
    // ========================================
    // Issue opcodes, loads first
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LBU = 4'd1,
        LH  = 4'd2,
        LHU = 4'd3,
        LW  = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } lsu_op_e;

    // Access width
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    // Memory port FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        WAIT = 2'd2
    } mem_state_e;

    // Byte lanes touched inside a 32-bit word, accesses are naturally aligned
    function automatic logic [XLEN/8-1:0] byte_mask(input mem_size_e size,
                                                    input logic [1:0] lo);
        unique case (size)
            BYTE:    return 4'b0001 << lo;
            HALF:    return 4'b0011 << {lo[1], 1'b0};
            default: return 4'b1111;
        endcase
    endfunction

endpackage

//--- hw/lsu_ifs.sv
// Store entering the queue, data already sits in its byte lanes
interface sq_push_if;
    import lsu_pkg::*;

    logic              valid;
    logic              ready;
    logic [ADDR_W-1:0] addr;
    logic [XLEN-1:0]   data;
    logic [XLEN/8-1:0] mask;

    modport master (output valid, addr, data, mask, input ready);
    modport slave  (input valid, addr, data, mask, output ready);
endinterface

// Forward query, answered combinationally by the queue
interface sq_lookup_if;
    import lsu_pkg::*;

    logic [ADDR_W-1:0] addr;
    logic [XLEN/8-1:0] mask;
    logic [XLEN/8-1:0] hit;
    logic              partial;
    logic [XLEN-1:0]   data;

    modport master (output addr, mask, input hit, partial, data);
    modport slave  (input addr, mask, output hit, partial, data);
endinterface

// One requester's link to the shared memory port
interface mem_req_if;
    import lsu_pkg::*;

    logic              valid;
    logic              ready;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [MEM_W-1:0]  wdata;
    logic [STRB_W-1:0] wstrb;
    logic              resp_valid;
    logic [MEM_W-1:0]  resp_data;

    modport master (output valid, write, addr, wdata, wstrb,
                    input ready, resp_valid, resp_data);
    modport slave  (input valid, write, addr, wdata, wstrb,
                    output ready, resp_valid, resp_data);
endinterface

//--- hw/lsu_agu.sv
module lsu_agu (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         issue_valid,
    output logic                         issue_ready,
    input  lsu_pkg::lsu_op_e             op,
    input  logic [lsu_pkg::ADDR_W-1:0]   base,
    input  logic [lsu_pkg::ADDR_W-1:0]   offset,
    input  logic [lsu_pkg::XLEN-1:0]     store_data,
    input  logic [lsu_pkg::TAG_W-1:0]    tag,
    sq_push_if.master                    push,
    output logic                         ld_valid,
    input  logic                         ld_ready,
    output logic [lsu_pkg::ADDR_W-1:0]   ld_addr,
    output lsu_pkg::mem_size_e           ld_size,
    output logic                         ld_unsigned,
    output logic [lsu_pkg::TAG_W-1:0]    ld_tag
);
    import lsu_pkg::*;

    logic              is_store;
    logic              is_unsigned;
    mem_size_e         size;
    logic [ADDR_W-1:0] addr;

    // ========================================
    // Decode
    // ========================================
    always_comb begin
        is_store    = 1'b0;
        is_unsigned = 1'b0;
        size        = WORD;
        unique case (op)
            LB:      size = BYTE;
            LBU:     begin size = BYTE; is_unsigned = 1'b1; end
            LH:      size = HALF;
            LHU:     begin size = HALF; is_unsigned = 1'b1; end
            SB:      begin size = BYTE; is_store = 1'b1; end
            SH:      begin size = HALF; is_store = 1'b1; end
            SW:      is_store = 1'b1;
            default: size = WORD;
        endcase
    end

    // Effective address, base plus offset
    assign addr = base + offset;

    // ========================================
    // Store side
    // ========================================
    // Data moves up into the lanes it will occupy
    assign push.valid = issue_valid && is_store;
    assign push.addr  = addr;
    assign push.data  = store_data << {addr[1:0], 3'b000};
    assign push.mask  = byte_mask(size, addr[1:0]);

    // ========================================
    // Load side
    // ========================================
    assign ld_valid    = issue_valid && !is_store;
    assign ld_addr     = addr;
    assign ld_size     = size;
    assign ld_unsigned = is_unsigned;
    assign ld_tag      = tag;

    // Ready comes from whichever unit takes this opcode
    assign issue_ready = is_store ? push.ready : ld_ready;

endmodule

//--- hw/lsu_store_queue.sv
module lsu_store_queue (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        commit,
    sq_push_if.slave    push,
    sq_lookup_if.slave  lookup,
    mem_req_if.master   drain
);
    import lsu_pkg::*;

    // Entry payload
    logic [ADDR_W-1:0]   addr_q [SQ_DEPTH];
    logic [XLEN-1:0]     data_q [SQ_DEPTH];
    logic [XLEN/8-1:0]   mask_q [SQ_DEPTH];
    // Entry state
    logic [SQ_DEPTH-1:0] valid_q;
    logic [SQ_DEPTH-1:0] cmt_q;
    // Oldest entry, next free slot, oldest uncommitted
    logic [SQ_PTR_W-1:0] head_q;
    logic [SQ_PTR_W-1:0] tail_q;
    logic [SQ_PTR_W-1:0] cmt_ptr_q;
    logic [SQ_PTR_W:0]   count_q;
    // Head write is out on the memory port
    logic                sent_q;

    logic push_fire;
    logic commit_fire;
    logic retire;

    assign push.ready  = (count_q != (SQ_PTR_W+1)'(SQ_DEPTH));
    assign push_fire   = push.valid && push.ready;
    // Pulse with nothing left to commit falls through
    assign commit_fire = commit && valid_q[cmt_ptr_q] && !cmt_q[cmt_ptr_q];
    assign retire      = sent_q && drain.resp_valid;

    // ========================================
    // Pointers and entry state
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= '0;
            cmt_q     <= '0;
            head_q    <= '0;
            tail_q    <= '0;
            cmt_ptr_q <= '0;
            count_q   <= '0;
            sent_q    <= 1'b0;
        end else begin
            if (push_fire) begin
                valid_q[tail_q] <= 1'b1;
                cmt_q[tail_q]   <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            if (commit_fire) begin
                cmt_q[cmt_ptr_q] <= 1'b1;
                cmt_ptr_q        <= cmt_ptr_q + 1'b1;
            end
            if (drain.valid && drain.ready) begin
                sent_q <= 1'b1;
            end
            // Write response frees the head
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
                sent_q          <= 1'b0;
            end
            unique case ({push_fire, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Payload written at the tail
    always_ff @(posedge clk) begin
        if (push_fire) begin
            addr_q[tail_q] <= push.addr;
            data_q[tail_q] <= push.data;
            mask_q[tail_q] <= push.mask;
        end
    end

    // ========================================
    // Forward search
    // ========================================
    // Walk oldest to youngest so a later store overwrites per byte
    always_comb begin
        logic [SQ_PTR_W-1:0] idx;
        lookup.hit  = '0;
        lookup.data = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            idx = head_q + SQ_PTR_W'(i);
            if (valid_q[idx] && (addr_q[idx][ADDR_W-1:2] == lookup.addr[ADDR_W-1:2])) begin
                for (int b = 0; b < XLEN/8; b++) begin
                    if (mask_q[idx][b] && lookup.mask[b]) begin
                        lookup.hit[b]         = 1'b1;
                        lookup.data[b*8 +: 8] = data_q[idx][b*8 +: 8];
                    end
                end
            end
        end
    end

    // Partial when some requested bytes are covered and others are not
    assign lookup.partial = (|lookup.hit) && (lookup.hit != lookup.mask);

    // ========================================
    // Drain
    // ========================================
    // Committed head goes out once with its word in the matching 64-bit half
    assign drain.valid = valid_q[head_q] && cmt_q[head_q] && !sent_q;
    assign drain.write = 1'b1;
    assign drain.addr  = addr_q[head_q];
    assign drain.wdata = addr_q[head_q][2] ? {data_q[head_q], {XLEN{1'b0}}}
                                           : {{XLEN{1'b0}}, data_q[head_q]};
    assign drain.wstrb = addr_q[head_q][2] ? {mask_q[head_q], 4'b0000}
                                           : {4'b0000, mask_q[head_q]};

endmodule

//--- hw/lsu_load_unit.sv
module lsu_load_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ld_valid,
    output logic                        ld_ready,
    input  logic [lsu_pkg::ADDR_W-1:0]  ld_addr,
    input  lsu_pkg::mem_size_e          ld_size,
    input  logic                        ld_unsigned,
    input  logic [lsu_pkg::TAG_W-1:0]   ld_tag,
    sq_lookup_if.master                 lookup,
    mem_req_if.master                   mem,
    output logic                        wb_valid,
    input  logic                        wb_ready,
    output logic [lsu_pkg::TAG_W-1:0]   wb_tag,
    output logic [lsu_pkg::XLEN-1:0]    wb_data
);
    import lsu_pkg::*;

    // Held memory load
    logic              req_pend_q;
    logic              wait_q;
    logic [ADDR_W-1:0] addr_q;
    mem_size_e         size_q;
    logic              uns_q;
    logic [TAG_W-1:0]  tag_q;

    logic              ld_fire;
    logic              full_hit;
    logic              resp_fire;
    logic [XLEN-1:0]   resp_word;
    logic [XLEN-1:0]   fwd_result;
    logic [XLEN-1:0]   mem_result;

    // Pick the addressed byte or half and extend it
    function automatic logic [XLEN-1:0] load_extend(input logic [XLEN-1:0] word,
                                                    input logic [1:0] lo,
                                                    input mem_size_e size,
                                                    input logic uns);
        logic [XLEN-1:0] sh;
        sh = word >> {lo, 3'b000};
        unique case (size)
            BYTE:    return uns ? {24'b0, sh[7:0]} : {{24{sh[7]}}, sh[7:0]};
            HALF:    return uns ? {16'b0, sh[15:0]} : {{16{sh[15]}}, sh[15:0]};
            default: return sh;
        endcase
    endfunction

    // ========================================
    // Acceptance
    // ========================================
    assign lookup.addr = ld_addr;
    assign lookup.mask = byte_mask(ld_size, ld_addr[1:0]);
    assign full_hit    = (lookup.hit == lookup.mask);

    // Idle, buffer empty, and no overlap that only some stores cover
    assign ld_ready  = !req_pend_q && !wait_q && !wb_valid && !lookup.partial;
    assign ld_fire   = ld_valid && ld_ready;
    assign resp_fire = wait_q && mem.resp_valid;

    // ========================================
    // Memory request
    // ========================================
    assign mem.valid = req_pend_q;
    assign mem.write = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign mem.wstrb = '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_pend_q <= 1'b0;
            wait_q     <= 1'b0;
        end else begin
            // No store covers it, so read memory
            if (ld_fire && !full_hit) begin
                req_pend_q <= 1'b1;
            end
            if (mem.valid && mem.ready) begin
                req_pend_q <= 1'b0;
                wait_q     <= 1'b1;
            end
            if (resp_fire) begin
                wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_fire) begin
            addr_q <= ld_addr;
            size_q <= ld_size;
            uns_q  <= ld_unsigned;
            tag_q  <= ld_tag;
        end
    end

    // ========================================
    // Result formation
    // ========================================
    assign fwd_result = load_extend(lookup.data, ld_addr[1:0], ld_size, ld_unsigned);
    // Word half chosen by address bit 2
    assign resp_word  = addr_q[2] ? mem.resp_data[63:32] : mem.resp_data[31:0];
    assign mem_result = load_extend(resp_word, addr_q[1:0], size_q, uns_q);

    // ========================================
    // Writeback buffer
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if ((ld_fire && full_hit) || resp_fire) begin
            wb_valid <= 1'b1;
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    // Held stable until the consumer takes it
    always_ff @(posedge clk) begin
        if (ld_fire && full_hit) begin
            wb_data <= fwd_result;
            wb_tag  <= ld_tag;
        end else if (resp_fire) begin
            wb_data <= mem_result;
            wb_tag  <= tag_q;
        end
    end

endmodule

//--- hw/lsu_mem_port.sv
module lsu_mem_port (
    input  logic                        clk,
    input  logic                        rst_n,
    mem_req_if.slave                    ld,
    mem_req_if.slave                    st,
    output logic                        mem_req_valid,
    input  logic                        mem_req_ready,
    output logic                        mem_req_write,
    output logic [lsu_pkg::ADDR_W-1:0]  mem_req_addr,
    output logic [lsu_pkg::MEM_W-1:0]   mem_req_wdata,
    output logic [lsu_pkg::STRB_W-1:0]  mem_req_wstrb,
    input  logic                        mem_resp_valid,
    input  logic [lsu_pkg::MEM_W-1:0]   mem_resp_data
);
    import lsu_pkg::*;

    mem_state_e        state_q;
    // High when the store drain owns the port
    logic              sel_st_q;
    logic [ADDR_W-1:0] sel_addr;

    // ========================================
    // Arbitration FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            sel_st_q <= 1'b0;
        end else begin
            unique case (state_q)
                IDLE: begin
                    // Load wins a tie
                    if (ld.valid) begin
                        sel_st_q <= 1'b0;
                        state_q  <= REQ;
                    end else if (st.valid) begin
                        sel_st_q <= 1'b1;
                        state_q  <= REQ;
                    end
                end
                REQ:     if (mem_req_ready) state_q <= WAIT;
                WAIT:    if (mem_resp_valid) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // ========================================
    // Request mux
    // ========================================
    assign sel_addr      = sel_st_q ? st.addr : ld.addr;
    assign mem_req_valid = (state_q == REQ);
    assign mem_req_write = sel_st_q ? st.write : ld.write;
    // 64-bit word address, lanes already placed by the requester
    assign mem_req_addr  = {sel_addr[ADDR_W-1:3], 3'b000};
    assign mem_req_wdata = sel_st_q ? st.wdata : ld.wdata;
    assign mem_req_wstrb = sel_st_q ? st.wstrb : ld.wstrb;

    // Handshake and response go back to the granted side only
    assign ld.ready      = (state_q == REQ) && !sel_st_q && mem_req_ready;
    assign st.ready      = (state_q == REQ) && sel_st_q && mem_req_ready;
    assign ld.resp_valid = (state_q == WAIT) && !sel_st_q && mem_resp_valid;
    assign st.resp_valid = (state_q == WAIT) && sel_st_q && mem_resp_valid;
    assign ld.resp_data  = mem_resp_data;
    assign st.resp_data  = mem_resp_data;

endmodule

//--- hw/lsu_top.sv
module lsu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    // Issue
    input  logic                        issue_valid,
    output logic                        issue_ready,
    input  lsu_pkg::lsu_op_e            op,
    input  logic [lsu_pkg::ADDR_W-1:0]  base,
    input  logic [lsu_pkg::ADDR_W-1:0]  offset,
    input  logic [lsu_pkg::XLEN-1:0]    store_data,
    input  logic [lsu_pkg::TAG_W-1:0]   tag,
    input  logic                        commit,
    // Writeback
    output logic                        wb_valid,
    input  logic                        wb_ready,
    output logic [lsu_pkg::TAG_W-1:0]   wb_tag,
    output logic [lsu_pkg::XLEN-1:0]    wb_data,
    // Data memory
    output logic                        mem_req_valid,
    input  logic                        mem_req_ready,
    output logic                        mem_req_write,
    output logic [lsu_pkg::ADDR_W-1:0]  mem_req_addr,
    output logic [lsu_pkg::MEM_W-1:0]   mem_req_wdata,
    output logic [lsu_pkg::STRB_W-1:0]  mem_req_wstrb,
    input  logic                        mem_resp_valid,
    input  logic [lsu_pkg::MEM_W-1:0]   mem_resp_data
);
    import lsu_pkg::*;

    // Decoded load from the address unit
    logic              ld_valid;
    logic              ld_ready;
    logic [ADDR_W-1:0] ld_addr;
    mem_size_e         ld_size;
    logic              ld_unsigned;
    logic [TAG_W-1:0]  ld_tag;

    sq_push_if   push_if ();
    sq_lookup_if lookup_if ();
    mem_req_if   ld_mem_if ();
    mem_req_if   st_mem_if ();

    lsu_agu i_lsu_agu (
        .clk, .rst_n, .issue_valid, .issue_ready, .op, .base, .offset,
        .store_data, .tag,
        .push (push_if.master),
        .ld_valid, .ld_ready, .ld_addr, .ld_size, .ld_unsigned, .ld_tag
    );

    lsu_store_queue i_lsu_store_queue (
        .clk, .rst_n, .commit,
        .push   (push_if.slave),
        .lookup (lookup_if.slave),
        .drain  (st_mem_if.master)
    );

    lsu_load_unit i_lsu_load_unit (
        .clk, .rst_n, .ld_valid, .ld_ready, .ld_addr, .ld_size, .ld_unsigned, .ld_tag,
        .lookup (lookup_if.master),
        .mem    (ld_mem_if.master),
        .wb_valid, .wb_ready, .wb_tag, .wb_data
    );

    lsu_mem_port i_lsu_mem_port (
        .clk, .rst_n,
        .ld (ld_mem_if.slave),
        .st (st_mem_if.slave),
        .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr,
        .mem_req_wdata, .mem_req_wstrb, .mem_resp_valid, .mem_resp_data
    );

endmodule

//--- sim/lsu_mem_model.sv
module lsu_mem_model (
    input  logic                        clk,
    input  logic                        mem_req_valid,
    output logic                        mem_req_ready,
    input  logic                        mem_req_write,
    input  logic [lsu_pkg::ADDR_W-1:0]  mem_req_addr,
    input  logic [lsu_pkg::MEM_W-1:0]   mem_req_wdata,
    input  logic [lsu_pkg::STRB_W-1:0]  mem_req_wstrb,
    output logic                        mem_resp_valid,
    output logic [lsu_pkg::MEM_W-1:0]   mem_resp_data
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    // Byte storage, address low byte picks the entry
    logic [7:0]        bytes_q [256];
    integer            seed;
    int                read_count;
    int                write_count;
    // Request log, oldest first
    logic              log_write [$];
    logic [STRB_W-1:0] log_strb [$];

    logic              req_write;
    logic [7:0]        req_addr;
    logic [MEM_W-1:0]  req_wdata;
    logic [STRB_W-1:0] req_wstrb;
    int                delay;

    initial begin
        seed           = 79;
        read_count     = 0;
        write_count    = 0;
        mem_req_ready  = 1'b0;
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
        // Initial pattern is the address XOR 0x5A
        for (int i = 0; i < 256; i++) begin
            bytes_q[i] = 8'(i) ^ 8'h5a;
        end
    end

    always begin
        @(negedge clk);
        mem_resp_valid = 1'b0;
        if (mem_req_valid) begin
            // Random ready delay of 0 to 3 cycles
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            req_write     = mem_req_write;
            req_addr      = mem_req_addr[7:0];
            req_wdata     = mem_req_wdata;
            req_wstrb     = mem_req_wstrb;
            mem_req_ready = 1'b1;
            @(negedge clk);
            mem_req_ready = 1'b0;
            log_write.push_back(req_write);
            log_strb.push_back(req_wstrb);
            if (req_write) begin
                write_count++;
                for (int k = 0; k < STRB_W; k++) begin
                    if (req_wstrb[k]) bytes_q[req_addr + 8'(k)] = req_wdata[k*8 +: 8];
                end
            end else begin
                read_count++;
            end
            // Response one cycle after the transfer
            for (int k = 0; k < STRB_W; k++) begin
                mem_resp_data[k*8 +: 8] = bytes_q[req_addr + 8'(k)];
            end
            mem_resp_valid = 1'b1;
        end
    end

endmodule

//--- sim/tb_lsu.sv
module tb_lsu;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int TIMEOUT = 200;

    logic              clk;
    logic              rst_n;
    logic              issue_valid;
    logic              issue_ready;
    lsu_op_e           op;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] offset;
    logic [XLEN-1:0]   store_data;
    logic [TAG_W-1:0]  tag;
    logic              commit;
    logic              wb_valid;
    logic              wb_ready;
    logic [TAG_W-1:0]  wb_tag;
    logic [XLEN-1:0]   wb_data;
    logic              mem_req_valid;
    logic              mem_req_ready;
    logic              mem_req_write;
    logic [ADDR_W-1:0] mem_req_addr;
    logic [MEM_W-1:0]  mem_req_wdata;
    logic [STRB_W-1:0] mem_req_wstrb;
    logic              mem_resp_valid;
    logic [MEM_W-1:0]  mem_resp_data;

    // Reference memory updated in program order
    logic [7:0]        ref_mem [256];
    int                errors;
    int                tests;

    lsu_top i_lsu_top (.*);

    lsu_mem_model i_mem (
        .clk, .mem_req_valid, .mem_req_ready, .mem_req_write, .mem_req_addr,
        .mem_req_wdata, .mem_req_wstrb, .mem_resp_valid, .mem_resp_data
    );

    always #50 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================
    task automatic abort(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $finish;
    endtask

    function automatic logic [XLEN-1:0] expect_load(input lsu_op_e o, input logic [7:0] a);
        logic [XLEN-1:0] w;
        w = {ref_mem[a + 8'd3], ref_mem[a + 8'd2], ref_mem[a + 8'd1], ref_mem[a]};
        case (o)
            LB:      return {{24{w[7]}}, w[7:0]};
            LBU:     return {24'h0, w[7:0]};
            LH:      return {{16{w[15]}}, w[15:0]};
            LHU:     return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic void ref_store(input lsu_op_e o, input logic [7:0] a,
                                      input logic [XLEN-1:0] d);
        int n;
        n = (o == SB) ? 1 : (o == SH) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            ref_mem[a + 8'(k)] = d[k*8 +: 8];
        end
    endfunction

    // Present an issue on the falling edge with base plus offset equal to the address
    task automatic drive_issue(input lsu_op_e o, input logic [7:0] a,
                               input logic [XLEN-1:0] d, input logic [TAG_W-1:0] t);
        @(negedge clk);
        issue_valid = 1'b1;
        op          = o;
        base        = ADDR_W'(a) - 32'd16;
        offset      = 32'd16;
        store_data  = d;
        tag         = t;
    endtask

    // Hold until the issue transfers, then drop valid
    task automatic wait_accept();
        int n;
        n = 0;
        #1;
        while (!issue_ready) begin
            @(negedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort("Timeout: issue never accepted");
        end
        @(posedge clk);
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic issue(input lsu_op_e o, input logic [7:0] a,
                         input logic [XLEN-1:0] d, input logic [TAG_W-1:0] t);
        drive_issue(o, a, d, t);
        wait_accept();
        if (o inside {SB, SH, SW}) ref_store(o, a, d);
    endtask

    // Issue must stay blocked for n cycles
    task automatic expect_stall(input int n);
        for (int i = 0; i < n; i++) begin
            #1;
            assert (issue_ready == 1'b0) else begin
                $display("CHECK FAILED issue_ready: got %h expected %h", issue_ready, 1'b0);
                errors++;
            end
            @(negedge clk);
        end
    endtask

    task automatic get_result(input logic [TAG_W-1:0] t, input logic [XLEN-1:0] exp);
        int n;
        n = 0;
        #1;
        while (!wb_valid) begin
            @(negedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort("Timeout: no writeback for a load");
        end
        assert (wb_tag == t) else begin
            $display("CHECK FAILED wb_tag: got %h expected %h", wb_tag, t);
            errors++;
        end
        assert (wb_data == exp) else begin
            $display("CHECK FAILED wb_data: got %h expected %h", wb_data, exp);
            errors++;
        end
    endtask

    task automatic load(input lsu_op_e o, input logic [7:0] a, input logic [TAG_W-1:0] t);
        issue(o, a, '0, t);
        get_result(t, expect_load(o, a));
    endtask

    task automatic pulse_commit();
        @(negedge clk);
        commit = 1'b1;
        @(negedge clk);
        commit = 1'b0;
    endtask

    task automatic wait_writes(input int target);
        int n;
        n = 0;
        #1;
        while (i_mem.write_count < target) begin
            @(negedge clk);
            #1;
            n++;
            if (n > TIMEOUT) abort("Timeout: store queue did not drain");
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("%s: %s", name, (errors == err_before) ? "ok" : "errors");
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_plain_loads();
        int e;
        e = errors;
        load(LB, 8'h85, 5'd1);
        load(LBU, 8'h85, 5'd2);
        load(LH, 8'h86, 5'd3);
        load(LHU, 8'h8a, 5'd4);
        load(LW, 8'h88, 5'd5);
        load(LW, 8'h8c, 5'd6);
        load(LBU, 8'h03, 5'd7);
        report("plain loads", e);
    endtask

    task automatic test_forwarding();
        int e;
        int reads;
        e = errors;
        reads = i_mem.read_count;
        issue(SW, 8'h20, 32'hcafef00d, '0);
        load(LW, 8'h20, 5'd8);
        load(LH, 8'h22, 5'd9);
        load(LB, 8'h21, 5'd10);
        assert (i_mem.read_count == reads) else begin
            $display("CHECK FAILED read_count: got %h expected %h", i_mem.read_count, reads);
            errors++;
        end
        pulse_commit();
        wait_writes(1);
        report("forwarding", e);
    endtask

    task automatic test_youngest();
        int e;
        e = errors;
        issue(SW, 8'h30, 32'h11223344, '0);
        issue(SB, 8'h31, 32'h000000ab, '0);
        load(LW, 8'h30, 5'd11);
        pulse_commit();
        pulse_commit();
        wait_writes(3);
        report("youngest wins", e);
    endtask

    task automatic test_partial();
        int e;
        e = errors;
        i_mem.log_write.delete();
        i_mem.log_strb.delete();
        issue(SB, 8'h52, 32'h0000007e, '0);
        drive_issue(LW, 8'h50, '0, 5'd12);
        expect_stall(3);
        pulse_commit();
        wait_accept();
        get_result(5'd12, expect_load(LW, 8'h50));
        // Write with the byte 2 strobe, then the read
        assert (i_mem.log_write.size() == 2 && i_mem.log_write[0] && !i_mem.log_write[1])
        else begin
            $display("Memory did not see the write before the read");
            errors++;
        end
        assert (i_mem.log_strb[0] == 8'h04) else begin
            $display("CHECK FAILED mem_req_wstrb: got %h expected %h", i_mem.log_strb[0], 8'h04);
            errors++;
        end
        report("partial overlap", e);
    endtask

    task automatic test_backpressure();
        int e;
        logic [XLEN-1:0] first;
        e = errors;
        // Previous result leaves the buffer before it is held
        @(negedge clk);
        wb_ready = 1'b0;
        first = expect_load(LW, 8'h60);
        issue(LW, 8'h60, '0, 5'd13);
        get_result(5'd13, first);
        drive_issue(LW, 8'h64, '0, 5'd14);
        expect_stall(3);
        assert (wb_valid && wb_data == first) else begin
            $display("CHECK FAILED wb_data: got %h expected %h", wb_data, first);
            errors++;
        end
        wb_ready = 1'b1;
        wait_accept();
        get_result(5'd14, expect_load(LW, 8'h64));
        // Fill the queue, then one store too many
        for (int i = 0; i < SQ_DEPTH; i++) begin
            issue(SW, 8'h70 + 8'(i * 4), 32'ha0b0c0d0 + i, '0);
        end
        drive_issue(SW, 8'h70, 32'h600dbeef, '0);
        expect_stall(3);
        pulse_commit();
        wait_accept();
        ref_store(SW, 8'h70, 32'h600dbeef);
        for (int i = 0; i < SQ_DEPTH; i++) begin
            pulse_commit();
        end
        wait_writes(9);
        for (int i = 0; i < SQ_DEPTH; i++) begin
            load(LW, 8'h70 + 8'(i * 4), 5'(16 + i));
        end
        report("back-pressure and queue full", e);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        op          = LB;
        base        = '0;
        offset      = '0;
        store_data  = '0;
        tag         = '0;
        commit      = 1'b0;
        wb_ready    = 1'b1;
        errors      = 0;
        tests       = 0;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 8'(i) ^ 8'h5a;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_plain_loads();
        test_forwarding();
        test_youngest();
        test_partial();
        test_backpressure();

        $display("Tests run: %0d, checks failed: %0d", tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/lsu_pkg.sv
hw/lsu_ifs.sv
hw/lsu_agu.sv
hw/lsu_store_queue.sv
hw/lsu_load_unit.sv
hw/lsu_mem_port.sv
hw/lsu_top.sv
sim/lsu_mem_model.sv
sim/tb_lsu.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_lsu
FILELIST  = tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
